// ==== include/soc_mem_config.svh ====
`ifndef SOC_MEM_CONFIG_SVH
`define SOC_MEM_CONFIG_SVH

// Bus widths
`define SOC_ADDR_W       32
`define SOC_DATA_W       32
`define SOC_BE_W         4

// On-chip SRAM
`define SOC_SRAM_WORDS   256
`define SOC_SRAM_BASE    32'h8000_0000

// Host address remap window, upper bound exclusive
`define SOC_REMAP_LO     32'h3000_0000
`define SOC_REMAP_HI     32'h8000_0000
`define SOC_REMAP_NIBBLE 4'h8

// Logic analyzer
`define SOC_LA_KEY       4'hA
`define SOC_LA_W         128

`endif

// ==== source/soc_mem_pkg.sv ====
`include "soc_mem_config.svh"

package soc_mem_pkg;

    // Bus payload
    typedef logic [`SOC_ADDR_W-1:0] addr_t;
    typedef logic [`SOC_DATA_W-1:0] data_t;
    typedef logic [`SOC_BE_W-1:0]   be_t;

    // Logic analyzer
    typedef logic [`SOC_LA_W-1:0]   la_word_t;
    typedef logic [2:0]             probe_sel_t;

    // Who gets the next response from the shared side
    typedef enum logic [1:0] {
        OWN_NONE = 2'd0,
        OWN_PRI  = 2'd1,
        OWN_SEC  = 2'd2
    } owner_e;

endpackage

// ==== source/obi_if.sv ====
`timescale 1ns/10ps

interface obi_if import soc_mem_pkg::*; ();

    // Request channel
    logic  req;
    logic  gnt;
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;

    // Response channel
    logic  rvalid;
    data_t rdata;

    modport manager (
        output req, addr, we, be, wdata,
        input  gnt, rvalid, rdata
    );

    modport subordinate (
        input  req, addr, we, be, wdata,
        output gnt, rvalid, rdata
    );

    // Observation only, for the debug probe
    modport monitor (
        input req, gnt, addr, we, be, wdata, rvalid, rdata
    );

endinterface

// ==== source/la_control.sv ====
`timescale 1ns/10ps
`include "soc_mem_config.svh"

module la_control import soc_mem_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n,
    input  la_word_t   la_data_i,
    output logic       rst_int_n_o,
    output logic       host_en_o,
    output logic       halt_o,
    output probe_sel_t probe_sel_o
);

    logic soft_rst_q;

    // Each field is live only when it holds the key
    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            soft_rst_q  <= 1'b0;
            host_en_o   <= 1'b0;
            halt_o      <= 1'b0;
            probe_sel_o <= '0;
        end else begin
            soft_rst_q  <= (la_data_i[3:0]  == `SOC_LA_KEY);
            host_en_o   <= (la_data_i[7:4]  == `SOC_LA_KEY);
            halt_o      <= (la_data_i[11:8] == `SOC_LA_KEY);
            probe_sel_o <= la_data_i[14:12];
        end
    end

    // Soft reset joins the pin reset for the rest of the design
    assign rst_int_n_o = rst_n & ~soft_rst_q;

endmodule

// ==== source/host_bridge.sv ====
`timescale 1ns/10ps
`include "soc_mem_config.svh"

module host_bridge import soc_mem_pkg::*; (
    input  logic  host_req_i,
    input  logic  host_we_i,
    input  addr_t host_addr_i,
    input  be_t   host_be_i,
    input  data_t host_wdata_i,
    output logic  host_gnt_o,
    output logic  host_rvalid_o,
    output data_t host_rdata_o,
    input  logic  host_en_i,
    obi_if.manager bus
);

    addr_t addr_remap;

    ////////////////////
    // Address remap
    ////////////////////

    always_comb begin
        if (host_addr_i >= `SOC_REMAP_LO && host_addr_i < `SOC_REMAP_HI) begin
            addr_remap = {`SOC_REMAP_NIBBLE, host_addr_i[`SOC_ADDR_W-5:0]};
        end else begin
            addr_remap = host_addr_i;
        end
    end

    ////////////////////
    // Request and response gating
    ////////////////////

    assign bus.req   = host_req_i & host_en_i;
    assign bus.addr  = addr_remap;
    assign bus.we    = host_we_i;
    assign bus.be    = host_be_i;
    assign bus.wdata = host_wdata_i;

    // Late responses are dropped while disabled
    assign host_gnt_o    = bus.gnt & host_en_i;
    assign host_rvalid_o = bus.rvalid & host_en_i;
    assign host_rdata_o  = bus.rdata;

endmodule

// ==== source/obi_mux_2_to_1.sv ====
`timescale 1ns/10ps

module obi_mux_2_to_1 import soc_mem_pkg::*; (
    input  logic clk_i,
    input  logic rst_n,
    input  logic halt_i,
    obi_if.subordinate pri,
    obi_if.subordinate sec,
    obi_if.manager     shr,
    output logic bad_state_o
);

    logic   sel_pri;
    logic   accept;
    owner_e owner_q;

    ////////////////////
    // Request path
    ////////////////////

    // Primary always wins when it asks
    assign sel_pri = pri.req;

    assign shr.req   = (pri.req | sec.req) & ~halt_i;
    assign shr.addr  = sel_pri ? pri.addr  : sec.addr;
    assign shr.we    = sel_pri ? pri.we    : sec.we;
    assign shr.be    = sel_pri ? pri.be    : sec.be;
    assign shr.wdata = sel_pri ? pri.wdata : sec.wdata;

    // Grants follow the shared side, never during halt
    assign pri.gnt = shr.gnt & ~halt_i & pri.req;
    assign sec.gnt = shr.gnt & ~halt_i & ~pri.req & sec.req;

    assign accept = shr.req & shr.gnt;

    ////////////////////
    // Response owner
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            owner_q <= OWN_NONE;
        end else if (accept) begin
            owner_q <= sel_pri ? OWN_PRI : OWN_SEC;
        end else if (shr.rvalid) begin
            owner_q <= OWN_NONE;
        end
    end

    assign pri.rvalid = shr.rvalid & (owner_q == OWN_PRI);
    assign sec.rvalid = shr.rvalid & (owner_q == OWN_SEC);
    assign pri.rdata  = shr.rdata;
    assign sec.rdata  = shr.rdata;

    // A response nobody asked for
    assign bad_state_o = shr.rvalid & (owner_q == OWN_NONE);

endmodule

// ==== source/sram_obi.sv ====
`timescale 1ns/10ps
`include "soc_mem_config.svh"

module sram_obi import soc_mem_pkg::*; (
    input  logic clk_i,
    input  logic rst_n,
    obi_if.subordinate bus,
    output logic illegal_o
);

    localparam int IDX_W = $clog2(`SOC_SRAM_WORDS);

    data_t            mem [`SOC_SRAM_WORDS];
    addr_t            offset;
    logic             in_range;
    logic [IDX_W-1:0] idx;
    logic             accept;
    logic             rvalid_q;
    data_t            rdata_q;

    // Addresses below the base wrap to large offsets
    assign offset   = bus.addr - `SOC_SRAM_BASE;
    assign in_range = offset < addr_t'(`SOC_SRAM_WORDS * 4);
    assign idx      = offset[IDX_W+1:2];

    // Single cycle memory, always ready
    assign bus.gnt = bus.req;
    assign accept  = bus.req & bus.gnt;

    always_ff @(posedge clk_i) begin
        if (accept && in_range && bus.we) begin
            for (int b = 0; b < `SOC_BE_W; b++) begin
                if (bus.be[b]) begin
                    mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // Out of range reads return zero
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rdata_q <= (in_range && !bus.we) ? mem[idx] : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            rvalid_q  <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            rvalid_q <= accept;
            if (accept && !in_range) begin
                illegal_o <= 1'b1;
            end
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

endmodule

// ==== source/debug_probe_mux.sv ====
`timescale 1ns/10ps
`include "soc_mem_config.svh"

module debug_probe_mux import soc_mem_pkg::*; (
    input  probe_sel_t probe_sel_i,
    obi_if.monitor     core_mon,
    obi_if.monitor     host_mon,
    obi_if.monitor     sram_mon,
    input  logic       illegal_i,
    input  logic       bad_state_i,
    input  logic       host_en_i,
    input  logic       halt_i,
    output la_word_t   la_data_o
);

    logic [103:0] core_fields;
    logic [103:0] host_fields;
    logic [103:0] sram_fields;

    // Field order from bit 16 up: addr, req, gnt, we, be, rvalid, rdata, wdata
    assign core_fields = {core_mon.wdata, core_mon.rdata, core_mon.rvalid, core_mon.be,
                          core_mon.we, core_mon.gnt, core_mon.req, core_mon.addr};
    assign host_fields = {host_mon.wdata, host_mon.rdata, host_mon.rvalid, host_mon.be,
                          host_mon.we, host_mon.gnt, host_mon.req, host_mon.addr};
    assign sram_fields = {sram_mon.wdata, sram_mon.rdata, sram_mon.rvalid, sram_mon.be,
                          sram_mon.we, sram_mon.gnt, sram_mon.req, sram_mon.addr};

    always_comb begin
        la_data_o        = '0;
        la_data_o[15:0]  = '1;
        case (probe_sel_i)
            3'd0: la_data_o[119:16] = core_fields;
            3'd1: la_data_o[119:16] = host_fields;
            3'd2: la_data_o[119:16] = sram_fields;
            3'd3: begin
                // Status bits, illegal at bit 16
                la_data_o[16] = illegal_i;
                la_data_o[17] = bad_state_i;
                la_data_o[18] = host_en_i;
                la_data_o[19] = halt_i;
            end
            default: la_data_o[`SOC_LA_W-1:16] = '0;
        endcase
    end

endmodule

// ==== source/soc_mem_top.sv ====
`timescale 1ns/10ps

module soc_mem_top import soc_mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n,
    input  la_word_t la_data_i,
    output la_word_t la_data_o,
    // Host port
    input  logic     host_req_i,
    output logic     host_gnt_o,
    input  addr_t    host_addr_i,
    input  logic     host_we_i,
    input  be_t      host_be_i,
    input  data_t    host_wdata_i,
    output logic     host_rvalid_o,
    output data_t    host_rdata_o,
    // Core data port
    input  logic     core_req_i,
    output logic     core_gnt_o,
    input  addr_t    core_addr_i,
    input  logic     core_we_i,
    input  be_t      core_be_i,
    input  data_t    core_wdata_i,
    output logic     core_rvalid_o,
    output data_t    core_rdata_o,
    output logic     illegal_o
);

    logic       rst_int_n;
    logic       host_en;
    logic       halt;
    logic       bad_state;
    probe_sel_t probe_sel;

    obi_if host_bus ();
    obi_if core_bus ();
    obi_if sram_bus ();

    ////////////////////
    // Core port onto its bus
    ////////////////////

    assign core_bus.req   = core_req_i;
    assign core_bus.addr  = core_addr_i;
    assign core_bus.we    = core_we_i;
    assign core_bus.be    = core_be_i;
    assign core_bus.wdata = core_wdata_i;
    assign core_gnt_o     = core_bus.gnt;
    assign core_rvalid_o  = core_bus.rvalid;
    assign core_rdata_o   = core_bus.rdata;

    ////////////////////
    // Blocks
    ////////////////////

    la_control u_la_control (
        .clk_i       (clk_i),
        .rst_n       (rst_n),
        .la_data_i   (la_data_i),
        .rst_int_n_o (rst_int_n),
        .host_en_o   (host_en),
        .halt_o      (halt),
        .probe_sel_o (probe_sel)
    );

    host_bridge u_host_bridge (
        .host_req_i    (host_req_i),
        .host_we_i     (host_we_i),
        .host_addr_i   (host_addr_i),
        .host_be_i     (host_be_i),
        .host_wdata_i  (host_wdata_i),
        .host_gnt_o    (host_gnt_o),
        .host_rvalid_o (host_rvalid_o),
        .host_rdata_o  (host_rdata_o),
        .host_en_i     (host_en),
        .bus           (host_bus.manager)
    );

    // Host is primary, core is secondary
    obi_mux_2_to_1 u_obi_mux (
        .clk_i       (clk_i),
        .rst_n       (rst_int_n),
        .halt_i      (halt),
        .pri         (host_bus.subordinate),
        .sec         (core_bus.subordinate),
        .shr         (sram_bus.manager),
        .bad_state_o (bad_state)
    );

    sram_obi u_sram (
        .clk_i     (clk_i),
        .rst_n     (rst_int_n),
        .bus       (sram_bus.subordinate),
        .illegal_o (illegal_o)
    );

    debug_probe_mux u_probe (
        .probe_sel_i (probe_sel),
        .core_mon    (core_bus.monitor),
        .host_mon    (host_bus.monitor),
        .sram_mon    (sram_bus.monitor),
        .illegal_i   (illegal_o),
        .bad_state_i (bad_state),
        .host_en_i   (host_en),
        .halt_i      (halt),
        .la_data_o   (la_data_o)
    );

endmodule

// ==== sim/soc_mem_chk.sv ====
`timescale 1ns/10ps

module soc_mem_chk import soc_mem_pkg::*; (
    input logic  clk_i,
    input logic  rst_n,
    input logic  rst_int_n_i,
    input logic  halt_i,
    input logic  host_req_i,
    input logic  host_gnt_i,
    input logic  host_rvalid_i,
    input addr_t host_addr_i,
    input logic  host_we_i,
    input be_t   host_be_i,
    input data_t host_wdata_i,
    input logic  core_req_i,
    input logic  core_gnt_i,
    input logic  core_rvalid_i,
    input addr_t core_addr_i,
    input logic  core_we_i,
    input be_t   core_be_i,
    input data_t core_wdata_i
);

    // Number of failed assertions so far
    int assert_failures = 0;

    // Nothing comes back while the pin reset is held
    a_no_rvalid_in_reset: assert property (@(negedge clk_i)
        !rst_n |-> !host_rvalid_i && !core_rvalid_i)
        else begin
            $error("rvalid seen during reset");
            assert_failures++;
        end

    ////////////////////
    // One response per accepted request
    ////////////////////

    a_host_response: assert property (@(posedge clk_i) disable iff (!rst_int_n_i)
        host_req_i && host_gnt_i |=> host_rvalid_i)
        else begin
            $error("host request accepted without a response one cycle later");
            assert_failures++;
        end

    a_core_response: assert property (@(posedge clk_i) disable iff (!rst_int_n_i)
        core_req_i && core_gnt_i |=> core_rvalid_i)
        else begin
            $error("core request accepted without a response one cycle later");
            assert_failures++;
        end

    ////////////////////
    // Pending requests hold their fields
    ////////////////////

    a_host_stable: assert property (@(posedge clk_i) disable iff (!rst_int_n_i)
        host_req_i && !host_gnt_i
        |=> $stable({host_addr_i, host_we_i, host_be_i, host_wdata_i}))
        else begin
            $error("host request fields changed while waiting for a grant");
            assert_failures++;
        end

    a_core_stable: assert property (@(posedge clk_i) disable iff (!rst_int_n_i)
        core_req_i && !core_gnt_i
        |=> $stable({core_addr_i, core_we_i, core_be_i, core_wdata_i}))
        else begin
            $error("core request fields changed while waiting for a grant");
            assert_failures++;
        end

    // Halt stalls every grant
    a_no_gnt_in_halt: assert property (@(posedge clk_i) disable iff (!rst_n)
        halt_i |-> !host_gnt_i && !core_gnt_i)
        else begin
            $error("grant issued while halt is active");
            assert_failures++;
        end

endmodule

bind soc_mem_top soc_mem_chk u_chk (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .rst_int_n_i   (rst_int_n),
    .halt_i        (halt),
    .host_req_i    (host_req_i),
    .host_gnt_i    (host_gnt_o),
    .host_rvalid_i (host_rvalid_o),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .core_req_i    (core_req_i),
    .core_gnt_i    (core_gnt_o),
    .core_rvalid_i (core_rvalid_o),
    .core_addr_i   (core_addr_i),
    .core_we_i     (core_we_i),
    .core_be_i     (core_be_i),
    .core_wdata_i  (core_wdata_i)
);

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam time HALF_PERIOD = 10ns;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Reset held for 16 cycles, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== sim/tb_soc_mem.sv ====
`timescale 1ns/10ps

module tb_soc_mem import soc_mem_pkg::*; ();

    localparam time QUARTER      = 5ns;
    localparam int  GNT_TIMEOUT  = 20;
    localparam int  RSP_TIMEOUT  = 10;
    localparam int  BLOCK_CYCLES = 8;
    localparam la_word_t HALT_MASK = 128'h0F00;

    logic     clk;
    logic     rst_n;
    la_word_t la_in;
    la_word_t la_out;
    logic     host_req, host_gnt, host_we, host_rvalid;
    addr_t    host_addr;
    be_t      host_be;
    data_t    host_wdata, host_rdata;
    logic     core_req, core_gnt, core_we, core_rvalid;
    addr_t    core_addr;
    be_t      core_be;
    data_t    core_wdata, core_rdata;
    logic     illegal;

    // Current golden line
    string    name;
    string    kind;
    la_word_t ctrl;
    logic     we_f;
    addr_t    addr;
    be_t      be;
    data_t    wdata;
    data_t    exp;

    int tests;
    int failed;
    int errors;
    int test_err;

    tb_clk_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    soc_mem_top UUT (
        .clk_i         (clk),
        .rst_n         (rst_n),
        .la_data_i     (la_in),
        .la_data_o     (la_out),
        .host_req_i    (host_req),
        .host_gnt_o    (host_gnt),
        .host_addr_i   (host_addr),
        .host_we_i     (host_we),
        .host_be_i     (host_be),
        .host_wdata_i  (host_wdata),
        .host_rvalid_o (host_rvalid),
        .host_rdata_o  (host_rdata),
        .core_req_i    (core_req),
        .core_gnt_o    (core_gnt),
        .core_addr_i   (core_addr),
        .core_we_i     (core_we),
        .core_be_i     (core_be),
        .core_wdata_i  (core_wdata),
        .core_rvalid_o (core_rvalid),
        .core_rdata_o  (core_rdata),
        .illegal_o     (illegal)
    );

    ////////////////////
    // Checks
    ////////////////////

    task automatic compare_data(input string tname, input data_t expv, input data_t actv);
        if (actv !== expv) begin
            $display("ERR %s: expected %h, actual %h", tname, expv, actv);
            test_err++;
        end
    endtask

    task automatic compare_la(input string tname, input la_word_t expv, input la_word_t actv);
        if (actv !== expv) begin
            $display("ERR %s: expected %h, actual %h", tname, expv, actv);
            test_err++;
        end
    endtask

    task automatic compare_flag(input string tname, input logic expv, input logic actv);
        if (actv !== expv) begin
            $display("ERR %s: expected %b, actual %b", tname, expv, actv);
            test_err++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s: %s", name, msg);
        test_err++;
    endtask

    ////////////////////
    // Port access
    ////////////////////

    function automatic logic port_gnt(input bit to_host);
        return to_host ? host_gnt : core_gnt;
    endfunction

    function automatic logic port_rvalid(input bit to_host);
        return to_host ? host_rvalid : core_rvalid;
    endfunction

    task automatic drive_req(input bit to_host, input logic w, input addr_t a,
                             input be_t b, input data_t d);
        if (to_host) begin
            host_req   = 1'b1;
            host_we    = w;
            host_addr  = a;
            host_be    = b;
            host_wdata = d;
        end else begin
            core_req   = 1'b1;
            core_we    = w;
            core_addr  = a;
            core_be    = b;
            core_wdata = d;
        end
    endtask

    // Only req drops, the fields stay put
    task automatic drop_req(input bit to_host);
        if (to_host) begin
            host_req = 1'b0;
        end else begin
            core_req = 1'b0;
        end
    endtask

    // Grant sampled mid low phase, acceptance at the next rising edge
    task automatic wait_grant(input bit to_host, output bit granted, input int limit);
        granted = 1'b0;
        for (int n = 0; n < limit && !granted; n++) begin
            #(QUARTER);
            if (port_gnt(to_host)) begin
                granted = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_response(input bit to_host, output data_t rd);
        bit seen;
        seen = 1'b0;
        rd   = '0;
        for (int n = 0; n < RSP_TIMEOUT && !seen; n++) begin
            if (port_rvalid(to_host)) begin
                seen = 1'b1;
                rd   = to_host ? host_rdata : core_rdata;
            end else begin
                @(negedge clk);
            end
        end
        if (!seen) begin
            note_failure("no response arrived after the grant");
        end
    endtask

    task automatic finish_access(input bit to_host, input bit granted, output data_t rd);
        if (granted) begin
            @(negedge clk);
            drop_req(to_host);
            wait_response(to_host, rd);
        end else begin
            drop_req(to_host);
            note_failure("request was never granted");
            rd = '0;
        end
    endtask

    task automatic set_ctrl(input la_word_t w);
        @(negedge clk);
        la_in = w;
        // One cycle to register, one more for the soft reset to act
        repeat (2) @(negedge clk);
    endtask

    ////////////////////
    // One golden operation
    ////////////////////

    task automatic run_op();
        bit       granted;
        data_t    rd;
        la_word_t status;
        case (kind)
            "core", "host": begin
                drive_req(kind == "host", we_f, addr, be, wdata);
                wait_grant(kind == "host", granted, GNT_TIMEOUT);
                finish_access(kind == "host", granted, rd);
                if (!we_f) compare_data(name, exp, rd);
            end
            "host_off": begin
                // No grant is the expected outcome
                drive_req(1'b1, we_f, addr, be, wdata);
                wait_grant(1'b1, granted, BLOCK_CYCLES);
                if (granted) begin
                    note_failure("host port was granted while disabled");
                    @(negedge clk);
                end
                drop_req(1'b1);
            end
            "halt": begin
                drive_req(1'b0, we_f, addr, be, wdata);
                wait_grant(1'b0, granted, BLOCK_CYCLES);
                if (granted) begin
                    note_failure("core port was granted during halt");
                end else begin
                    la_in = ctrl & ~HALT_MASK;
                    wait_grant(1'b0, granted, GNT_TIMEOUT);
                end
                finish_access(1'b0, granted, rd);
                if (!we_f) compare_data(name, exp, rd);
            end
            "both": begin
                // Host writes wdata at addr, core writes the last column at addr + 4
                drive_req(1'b1, 1'b1, addr, be, wdata);
                drive_req(1'b0, 1'b1, addr + 4, be, exp);
                #(QUARTER);
                if (!(host_gnt === 1'b1 && core_gnt === 1'b0)) begin
                    note_failure("host was not granted first under contention");
                end
                @(negedge clk);
                drop_req(1'b1);
                wait_response(1'b1, rd);
                wait_grant(1'b0, granted, GNT_TIMEOUT);
                finish_access(1'b0, granted, rd);
            end
            "flag": begin
                compare_flag(name, exp[0], illegal);
            end
            "probe": begin
                status        = '0;
                status[15:0]  = '1;
                status[19:16] = exp[3:0];
                compare_la(name, status, la_out);
            end
            default: note_failure("unknown operation kind in the golden file");
        endcase
    endtask

    initial begin
        int          fd;
        int          n_read;
        string       line;
        la_in      = '0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_be    = '0;
        host_wdata = '0;
        core_req   = 1'b0;
        core_we    = 1'b0;
        core_addr  = '0;
        core_be    = '0;
        core_wdata = '0;
        tests      = 0;
        failed     = 0;
        errors     = 0;
        void'($urandom(32'hf6cb));
        fd         = $fopen("sim/soc_mem_golden.txt", "r");

        for (int i = 0; i < 40 && rst_n !== 1'b1; i++) begin
            @(negedge clk);
        end

        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            errors++;
        end else if (fd == 0) begin
            $display("Golden file sim/soc_mem_golden.txt could not be opened");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n_read = $fgets(line, fd);
                if (n_read > 0 && line.len() > 1 && line[0] != "#") begin
                    n_read = $sscanf(line, "%s %s %h %h %h %h %h %h",
                                     name, kind, ctrl, we_f, addr, be, wdata, exp);
                    if (n_read != 8) begin
                        $display("Malformed golden line: %s", line);
                        errors++;
                    end else begin
                        tests++;
                        test_err = 0;
                        set_ctrl(ctrl);
                        repeat ($urandom_range(3, 0)) @(negedge clk);
                        run_op();
                        if (test_err == 0) begin
                            $display("PASS %s", name);
                        end else begin
                            $display("FAIL %s", name);
                            failed++;
                            errors += test_err;
                        end
                    end
                end
            end
            $fclose(fd);
        end

        if (UUT.u_chk.assert_failures != 0) begin
            $display("Bound assertions failed %0d times", UUT.u_chk.assert_failures);
            errors += UUT.u_chk.assert_failures;
        end

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed, errors);
        if (errors == 0 && tests > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sim/soc_mem_golden.txt ====
# name kind ctrl we addr be wdata expected (all numbers hex)
# kinds: core, host, host_off, halt, both, flag, probe
core_wr_full      core     0    1 80000000 f 11223344 00000000
core_wr_part      core     0    1 80000000 5 aabbccdd 00000000
core_rd_merge     core     0    0 80000000 f 00000000 11bb33dd
host_wr_remap     host     a0   1 30000010 f cafef00d 00000000
core_rd_remap     core     a0   0 80000010 f 00000000 cafef00d
host_wr_disabled  host_off 0    1 30000010 f 12345678 00000000
core_rd_old       core     0    0 80000010 f 00000000 cafef00d
core_rd_halt      halt     a00  0 80000000 f 00000000 11bb33dd
both_wr           both     a0   1 80000020 f 0badf00d 5eed1234
host_rd_both      host     a0   0 30000020 f 00000000 0badf00d
core_rd_both      core     a0   0 80000024 f 00000000 5eed1234
core_wr_illegal   core     0    1 80000400 f deadbeef 00000000
core_rd_illegal   core     0    0 80000400 f 00000000 00000000
flag_set          flag     0    0 00000000 0 00000000 00000001
probe_status      probe    30a0 0 00000000 0 00000000 00000005
flag_soft_rst     flag     a    0 00000000 0 00000000 00000000
core_rd_after_rst core     0    0 80000000 f 00000000 11bb33dd

// ==== files.f ====
+incdir+include
source/soc_mem_pkg.sv
source/obi_if.sv
source/la_control.sv
source/host_bridge.sv
source/obi_mux_2_to_1.sv
source/sram_obi.sv
source/debug_probe_mux.sv
source/soc_mem_top.sv
sim/soc_mem_chk.sv
sim/tb_clk_gen.sv
sim/tb_soc_mem.sv
